// File: lrelu_config.svh
`ifndef LRELU_CONFIG_SVH
`define LRELU_CONFIG_SVH

// number of parallel lanes
`define LRELU_UNITS 4

// accumulator word from the convolution core
`define LRELU_WIDTH_IN 16

// activation output word
`define LRELU_WIDTH_OUT 8

// q8.8 fixed point
`define LRELU_FRAC_BITS 8

// leaky slope, 26/256 is roughly 0.1
`define LRELU_ALPHA 26

// unity slope in q8.8
`define LRELU_ONE 256

// coefficient members per kernel position
`define LRELU_MEMBERS 2

// table depths per kernel mode
`define LRELU_DEPTH_3X3 (`LRELU_MEMBERS)
`define LRELU_DEPTH_1X1 (3 * `LRELU_MEMBERS)

// wide enough for the 1x1 depth
`define LRELU_ADDR_BITS 3

`endif

// File: lrelu_cfg_pkg.sv
`default_nettype none

`include "lrelu_config.svh"

package lrelu_cfg_pkg;

  // coefficients are q8.8, same width as the accumulator word
  localparam int COEFF_BITS = `LRELU_WIDTH_IN;

  typedef logic signed [COEFF_BITS-1:0] coeff_t;

  typedef logic [`LRELU_ADDR_BITS-1:0] tbl_addr_t;

  // loader target, also the write target seen by the store
  typedef enum logic [1:0] {
    SEL_D = 2'd0,
    SEL_A = 2'd1,
    SEL_B = 2'd2
  } cfg_sel_e;

  // one coefficient write, 1 + 2 + 3 + 16 bits
  typedef struct packed {
    logic      wr;
    cfg_sel_e  target;
    tbl_addr_t addr;
    coeff_t    data;
  } cfg_wr_t;

endpackage

`default_nettype wire

// File: lrelu_data_pkg.sv
`default_nettype none

`include "lrelu_config.svh"

package lrelu_data_pkg;

  // kept local so this package stands on its own
  localparam int COEFF_FIELD_BITS = 16;

  // intermediate width for products and sums
  localparam int ACC_BITS = 32;

  typedef logic signed [`LRELU_WIDTH_IN-1:0]  in_word_t;
  typedef logic signed [`LRELU_WIDTH_OUT-1:0] out_word_t;
  typedef logic signed [ACC_BITS-1:0]         acc_t;

  // sideband bits that travel with each data beat
  typedef struct packed {
    logic is_lrelu;
    logic is_1x1;
  } data_user_t;

  // lane 0 sits in the low bits
  typedef in_word_t  [`LRELU_UNITS-1:0] in_lanes_t;
  typedef out_word_t [`LRELU_UNITS-1:0] out_lanes_t;

  // coefficients applied to the current beat
  typedef struct packed {
    logic signed [COEFF_FIELD_BITS-1:0] a;
    logic signed [COEFF_FIELD_BITS-1:0] b;
    logic signed [COEFF_FIELD_BITS-1:0] d;
  } coeff_set_t;

endpackage

`default_nettype wire

// File: lrelu_config_loader.sv
`default_nettype none

`include "lrelu_config.svh"

module lrelu_config_loader (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   s_valid_config,
  input  lrelu_cfg_pkg::coeff_t  s_data_config,
  input  logic                   is_1x1_config,
  output lrelu_cfg_pkg::cfg_wr_t cfg_wr
);

  import lrelu_cfg_pkg::*;

  cfg_sel_e  sel;
  cfg_sel_e  sel_next;
  tbl_addr_t addr;
  tbl_addr_t addr_next;
  tbl_addr_t addr_last;

  // registered write towards the store
  logic      strobe_q;
  cfg_sel_e  target_q;
  tbl_addr_t addr_q;
  coeff_t    data_q;

  // last table entry of the current kernel mode
  assign addr_last = is_1x1_config ? tbl_addr_t'(`LRELU_DEPTH_1X1 - 1)
                                   : tbl_addr_t'(`LRELU_DEPTH_3X3 - 1);

  // order is D, then the A table, then the B table, then D again
  always_comb begin
    sel_next  = sel;
    addr_next = addr;
    case (sel)
      SEL_D: begin
        sel_next  = SEL_A;
        addr_next = '0;
      end
      SEL_A, SEL_B: begin
        if (addr == addr_last) begin
          addr_next = '0;
          sel_next  = (sel == SEL_A) ? SEL_B : SEL_D;
        end else begin
          addr_next = addr + 1'b1;
        end
      end
      default: begin
        sel_next  = SEL_D;
        addr_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sel      <= SEL_D;
      addr     <= '0;
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= s_valid_config;
      if (s_valid_config) begin
        sel  <= sel_next;
        addr <= addr_next;
      end
    end
  end

  // payload is only looked at while the strobe is high
  always_ff @(posedge clk) begin
    if (s_valid_config) begin
      target_q <= sel;
      addr_q   <= addr;
      data_q   <= s_data_config;
    end
  end

  assign cfg_wr = '{wr: strobe_q, target: target_q, addr: addr_q, data: data_q};

endmodule

`default_nettype wire

// File: lrelu_coeff_store.sv
`default_nettype none

`include "lrelu_config.svh"

module lrelu_coeff_store (
  input  logic                      clk,
  input  logic                      rst_n,
  input  lrelu_cfg_pkg::cfg_wr_t    cfg_wr,
  input  logic                      s_valid,
  input  lrelu_data_pkg::data_user_t s_user,
  output lrelu_data_pkg::coeff_set_t coeffs
);

  import lrelu_cfg_pkg::*;

  // shared offset
  coeff_t d_q;

  // per-channel scale and bias, sized for 1x1 mode
  coeff_t a_tbl [`LRELU_DEPTH_1X1];
  coeff_t b_tbl [`LRELU_DEPTH_1X1];

  tbl_addr_t rd_idx;
  tbl_addr_t rd_last;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      d_q <= '0;
      for (int i = 0; i < `LRELU_DEPTH_1X1; i++) begin
        a_tbl[i] <= '0;
        b_tbl[i] <= '0;
      end
    end else if (cfg_wr.wr) begin
      case (cfg_wr.target)
        SEL_D:   d_q <= cfg_wr.data;
        SEL_A:   a_tbl[cfg_wr.addr] <= cfg_wr.data;
        SEL_B:   b_tbl[cfg_wr.addr] <= cfg_wr.data;
        default: ;
      endcase
    end
  end

  // wrap point follows the mode of the beat being read
  assign rd_last = s_user.is_1x1 ? tbl_addr_t'(`LRELU_DEPTH_1X1 - 1)
                                 : tbl_addr_t'(`LRELU_DEPTH_3X3 - 1);

  // cyclic read index, one step per beat
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_idx <= '0;
    end else if (cfg_wr.wr) begin
      // a reload restarts the channel sequence
      rd_idx <= '0;
    end else if (s_valid) begin
      if (rd_idx == rd_last) begin
        rd_idx <= '0;
      end else begin
        rd_idx <= rd_idx + 1'b1;
      end
    end
  end

  // read is combinational so the datapath samples it with the beat
  assign coeffs = '{a: a_tbl[rd_idx], b: b_tbl[rd_idx], d: d_q};

endmodule

`default_nettype wire

// File: lrelu_datapath.sv
`default_nettype none

`include "lrelu_config.svh"

module lrelu_datapath (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       s_valid,
  input  lrelu_data_pkg::in_lanes_t  s_data,
  input  lrelu_data_pkg::data_user_t s_user,
  input  lrelu_data_pkg::coeff_set_t coeffs,
  output logic                       m_valid,
  output lrelu_data_pkg::out_lanes_t m_data,
  output lrelu_data_pkg::data_user_t m_user
);

  import lrelu_data_pkg::*;

  localparam acc_t SAT_MAX = acc_t'((1 <<< (`LRELU_WIDTH_OUT - 1)) - 1);
  localparam acc_t SAT_MIN = -SAT_MAX - 1;

  // stage 1
  logic       valid_1;
  data_user_t user_1;
  logic signed [COEFF_FIELD_BITS-1:0] d_1;
  acc_t       y1_q [`LRELU_UNITS];

  // stage 2
  logic       valid_2;
  data_user_t user_2;
  acc_t       y2_q [`LRELU_UNITS];

  // floor(x*a/256) + b
  function automatic acc_t scale_bias(
    input in_word_t                           x,
    input logic signed [COEFF_FIELD_BITS-1:0] a,
    input logic signed [COEFF_FIELD_BITS-1:0] b
  );
    acc_t prod;
    prod = acc_t'(x) * acc_t'(a);
    return (prod >>> `LRELU_FRAC_BITS) + acc_t'(b);
  endfunction

  // leaky slope only on negative values, then the shared offset
  function automatic acc_t leaky_offset(
    input acc_t                               y,
    input logic                               is_lrelu,
    input logic signed [COEFF_FIELD_BITS-1:0] d
  );
    acc_t slope;
    acc_t prod;
    slope = (is_lrelu && (y < 0)) ? acc_t'(`LRELU_ALPHA) : acc_t'(`LRELU_ONE);
    prod  = y * slope;
    return (prod >>> `LRELU_FRAC_BITS) + acc_t'(d);
  endfunction

  function automatic out_word_t saturate(input acc_t y);
    if (y > SAT_MAX) begin
      return out_word_t'(SAT_MAX);
    end else if (y < SAT_MIN) begin
      return out_word_t'(SAT_MIN);
    end
    return out_word_t'(y);
  endfunction

  // valid chain, three cycles end to end
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_1 <= 1'b0;
      valid_2 <= 1'b0;
      m_valid <= 1'b0;
    end else begin
      valid_1 <= s_valid;
      valid_2 <= valid_1;
      m_valid <= valid_2;
    end
  end

  always_ff @(posedge clk) begin
    user_1 <= s_user;
    d_1    <= coeffs.d;
    user_2 <= user_1;
    m_user <= user_2;
    for (int i = 0; i < `LRELU_UNITS; i++) begin
      y1_q[i]   <= scale_bias(s_data[i], coeffs.a, coeffs.b);
      y2_q[i]   <= leaky_offset(y1_q[i], user_1.is_lrelu, d_1);
      m_data[i] <= saturate(y2_q[i]);
    end
  end

endmodule

`default_nettype wire

// File: lrelu_engine.sv
`default_nettype none

module lrelu_engine (
  input  logic                       clk,
  input  logic                       rst_n,
  // data beat in
  input  logic                       s_valid,
  input  lrelu_data_pkg::in_lanes_t  s_data,
  input  lrelu_data_pkg::data_user_t s_user,
  // activated beat out
  output logic                       m_valid,
  output lrelu_data_pkg::out_lanes_t m_data,
  output lrelu_data_pkg::data_user_t m_user,
  // coefficient stream
  input  logic                       s_valid_config,
  input  lrelu_cfg_pkg::coeff_t      s_data_config,
  input  logic                       is_1x1_config
);

  import lrelu_cfg_pkg::*;
  import lrelu_data_pkg::*;

  cfg_wr_t    cfg_wr;
  coeff_set_t coeffs;

  lrelu_config_loader config_loader_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .s_valid_config (s_valid_config),
    .s_data_config  (s_data_config),
    .is_1x1_config  (is_1x1_config),
    .cfg_wr         (cfg_wr)
  );

  lrelu_coeff_store coeff_store_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg_wr  (cfg_wr),
    .s_valid (s_valid),
    .s_user  (s_user),
    .coeffs  (coeffs)
  );

  lrelu_datapath datapath_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_data  (s_data),
    .s_user  (s_user),
    .coeffs  (coeffs),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_user  (m_user)
  );

endmodule

`default_nettype wire

// File: lrelu_engine_assert.sv
`default_nettype none

module lrelu_engine_assert (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       s_valid,
  input lrelu_data_pkg::data_user_t s_user,
  input logic                       m_valid,
  input lrelu_data_pkg::data_user_t m_user
);

  timeunit 1ns;
  timeprecision 1ps;

  // synchronous reset clears the output strobe
  valid_low_in_reset: assert property (@(posedge clk) !rst_n |=> !m_valid)
    else $error("m_valid high after a reset cycle");

  // fixed three stage pipeline
  valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid == $past(s_valid, 3))
    else $error("m_valid does not follow s_valid by three cycles");

  user_latency: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid |-> m_user == $past(s_user, 3))
    else $error("m_user does not follow s_user by three cycles");

endmodule

bind lrelu_engine lrelu_engine_assert lrelu_engine_assert_inst (
  .clk     (clk),
  .rst_n   (rst_n),
  .s_valid (s_valid),
  .s_user  (s_user),
  .m_valid (m_valid),
  .m_user  (m_user)
);

`default_nettype wire

// File: tb_lrelu_engine.sv
`default_nettype none

`include "lrelu_config.svh"

module tb_lrelu_engine;

  timeunit 1ns;
  timeprecision 1ps;

  import lrelu_cfg_pkg::*;
  import lrelu_data_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_TESTS    = 6;
  localparam int ROW_IDLE     = 0;
  localparam int ROW_CFG      = 1;
  localparam int ROW_BEAT     = 2;

  // stimulus row with the expected lanes from the reference model
  typedef struct {
    int         test;
    int         kind;
    coeff_t     word;
    logic       mode;
    in_lanes_t  lanes;
    data_user_t user;
    out_lanes_t exp_data;
  } row_t;

  typedef struct {
    int         test;
    out_lanes_t data;
    data_user_t user;
  } expect_t;

  logic       clk;
  logic       rst_n;
  logic       s_valid;
  in_lanes_t  s_data;
  data_user_t s_user;
  logic       m_valid;
  out_lanes_t m_data;
  data_user_t m_user;
  logic       s_valid_config;
  coeff_t     s_data_config;
  logic       is_1x1_config;

  row_t       rows [$];
  expect_t    exp_q [$];
  string      test_name [NUM_TESTS];
  int         test_err [NUM_TESTS];
  int         test_beats [NUM_TESTS];
  int         errors;
  int         cur_test;
  logic [2:0] valid_hist;
  bit         table_ready = 1'b0;

  lrelu_engine lrelu_engine_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .s_valid        (s_valid),
    .s_data         (s_data),
    .s_user         (s_user),
    .m_valid        (m_valid),
    .m_data         (m_data),
    .m_user         (m_user),
    .s_valid_config (s_valid_config),
    .s_data_config  (s_data_config),
    .is_1x1_config  (is_1x1_config)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp, input int test);
    if (got !== exp) begin
      $display("CHECK FAILED: %s got 0x%0h expected 0x%0h (test %0d)", name, got, exp, test);
      errors++;
      test_err[test]++;
    end
  endtask

  function automatic row_t make_row(input int test, input int kind);
    row_t r;
    r.test     = test;
    r.kind     = kind;
    r.word     = '0;
    r.mode     = 1'b0;
    r.lanes    = '0;
    r.user     = '0;
    r.exp_data = '0;
    return r;
  endfunction

  task automatic config_row(input int test, input int word, input logic mode);
    row_t r;
    r      = make_row(test, ROW_CFG);
    r.word = coeff_t'(word);
    r.mode = mode;
    rows.push_back(r);
  endtask

  task automatic beat_row(input int test, input logic lrelu, input logic one_by_one,
                          input int l0, input int l1, input int l2, input int l3);
    row_t r;
    r               = make_row(test, ROW_BEAT);
    r.user.is_lrelu = lrelu;
    r.user.is_1x1   = one_by_one;
    r.lanes[0]      = in_word_t'(l0);
    r.lanes[1]      = in_word_t'(l1);
    r.lanes[2]      = in_word_t'(l2);
    r.lanes[3]      = in_word_t'(l3);
    rows.push_back(r);
  endtask

  // random lanes and slope flag in 3x3 mode
  task automatic random_beat_row(input int test);
    row_t r;
    r               = make_row(test, ROW_BEAT);
    r.user.is_lrelu = 1'($urandom());
    for (int k = 0; k < `LRELU_UNITS; k++) begin
      r.lanes[k] = in_word_t'($urandom());
    end
    rows.push_back(r);
  endtask

  task automatic idle_row(input int test);
    rows.push_back(make_row(test, ROW_IDLE));
  endtask

  task automatic build_table();
    // D, A0, A1, B0, B1 in 3x3 mode
    config_row(1, 5, 1'b0);
    config_row(1, 512, 1'b0);
    config_row(1, 128, 1'b0);
    config_row(1, -10, 1'b0);
    config_row(1, 20, 1'b0);
    beat_row(1, 1'b0, 1'b0, 10, -7, 33, -50);
    beat_row(1, 1'b0, 1'b0, 10, -7, 33, -50);
    beat_row(1, 1'b0, 1'b0, 100, 200, -300, 0);
    beat_row(2, 1'b1, 1'b0, -100, 40, -3, 60);
    beat_row(2, 1'b1, 1'b0, -100, 40, -3, 60);
    beat_row(2, 1'b1, 1'b0, -1000, 1000, -1, 1);
    beat_row(3, 1'b0, 1'b0, 32767, -32768, 1000, -1000);
    beat_row(3, 1'b0, 1'b0, 32767, -32768, 1000, -1000);
    beat_row(3, 1'b1, 1'b0, 32767, -32768, 30000, -30000);
    // full 1x1 reload with six A and six B words
    config_row(4, -3, 1'b1);
    config_row(4, 256, 1'b1);
    config_row(4, 384, 1'b1);
    config_row(4, 128, 1'b1);
    config_row(4, -256, 1'b1);
    config_row(4, 64, 1'b1);
    config_row(4, 512, 1'b1);
    for (int i = 0; i < 6; i++) begin
      config_row(4, i, 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      beat_row(4, 1'b0, 1'b1, 100, -100, 50, 7);
    end
    config_row(4, 9, 1'b0);
    for (int i = 0; i < 5; i++) begin
      beat_row(4, 1'b0, 1'b0, 100, -100, 50, 7);
    end
    // loader now points at A0
    config_row(4, 768, 1'b0);
    for (int i = 0; i < 3; i++) begin
      beat_row(4, 1'b1, 1'b0, 100, -100, 50, 7);
    end
    for (int i = 0; i < 10; i++) begin
      random_beat_row(5);
    end
    for (int i = 0; i < 3; i++) begin
      idle_row(5);
    end
    for (int i = 0; i < 4; i++) begin
      random_beat_row(5);
    end
  endtask

  function automatic longint floor_shift8(input longint p);
    if (p >= 0) begin
      return p / 256;
    end
    return -((-p + 255) / 256);
  endfunction

  function automatic longint clamp8(input longint v);
    if (v > 127) begin
      return 127;
    end else if (v < -128) begin
      return -128;
    end
    return v;
  endfunction

  // walks the table in order and tracks loader, tables and read index
  task automatic model_table();
    coeff_t m_d;
    coeff_t m_a [`LRELU_DEPTH_1X1];
    coeff_t m_b [`LRELU_DEPTH_1X1];
    int     sel;
    int     waddr;
    int     ridx;
    int     depth;
    longint y1;
    longint y2;
    longint slope;
    m_d   = '0;
    sel   = 0;
    waddr = 0;
    ridx  = 0;
    for (int j = 0; j < `LRELU_DEPTH_1X1; j++) begin
      m_a[j] = '0;
      m_b[j] = '0;
    end
    foreach (rows[i]) begin
      if (rows[i].kind == ROW_CFG) begin
        depth = rows[i].mode ? `LRELU_DEPTH_1X1 : `LRELU_DEPTH_3X3;
        if (sel == 0) begin
          m_d   = rows[i].word;
          sel   = 1;
          waddr = 0;
        end else begin
          if (sel == 1) begin
            m_a[waddr] = rows[i].word;
          end else begin
            m_b[waddr] = rows[i].word;
          end
          if (waddr == depth - 1) begin
            waddr = 0;
            sel   = (sel == 1) ? 2 : 0;
          end else begin
            waddr++;
          end
        end
        ridx = 0;
      end else if (rows[i].kind == ROW_BEAT) begin
        for (int k = 0; k < `LRELU_UNITS; k++) begin
          y1 = floor_shift8(longint'(rows[i].lanes[k]) * longint'(m_a[ridx]))
               + longint'(m_b[ridx]);
          slope = (rows[i].user.is_lrelu && y1 < 0) ? longint'(`LRELU_ALPHA)
                                                    : longint'(`LRELU_ONE);
          y2 = floor_shift8(y1 * slope) + longint'(m_d);
          rows[i].exp_data[k] = out_word_t'(clamp8(y2));
        end
        depth = rows[i].user.is_1x1 ? `LRELU_DEPTH_1X1 : `LRELU_DEPTH_3X3;
        ridx  = (ridx == depth - 1) ? 0 : ridx + 1;
      end
    end
  endtask

  task automatic drive_idle();
    @(posedge clk);
    s_valid        <= 1'b0;
    s_valid_config <= 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    expect_t e;
    @(posedge clk);
    s_valid        <= (r.kind == ROW_BEAT);
    s_data         <= r.lanes;
    s_user         <= r.user;
    s_valid_config <= (r.kind == ROW_CFG);
    s_data_config  <= r.word;
    is_1x1_config  <= r.mode;
    if (r.kind == ROW_BEAT) begin
      e.test = r.test;
      e.data = r.exp_data;
      e.user = r.user;
      exp_q.push_back(e);
    end
    // a write lands two edges later so the next beat waits a cycle
    if (r.kind == ROW_CFG) begin
      drive_idle();
    end
  endtask

  // outputs sampled away from the driving edge
  always @(negedge clk) begin
    expect_t e;
    if (!rst_n) begin
      valid_hist = 3'b000;
    end else begin
      check_value("m_valid", 64'(m_valid), 64'(valid_hist[2]), cur_test);
      if (m_valid) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: output beat with no input beat pending (test %0d)", cur_test);
          errors++;
          test_err[cur_test]++;
        end else begin
          e = exp_q.pop_front();
          check_value("m_data", 64'(m_data), 64'(e.data), e.test);
          check_value("m_user", 64'(m_user), 64'(e.user), e.test);
          test_beats[e.test]++;
        end
      end
      valid_hist = {valid_hist[1:0], s_valid};
    end
  end

  initial begin
    longint limit;
    wait (table_ready);
    limit = longint'(rows.size()) * 2 + RESET_CYCLES + 20 * NUM_TESTS;
    #(limit * CLK_PERIOD);
    $display("ERROR: timeout after %0d cycles, the run did not reach its end", limit);
    $display("Test failed");
    $finish;
  end

  initial begin
    int total;
    void'($urandom(32'h8c36));
    rst_n          = 1'b0;
    // a beat on the first reset edge must not reach the output
    s_valid        = 1'b1;
    s_data         = '0;
    s_user         = '0;
    s_valid_config = 1'b0;
    s_data_config  = '0;
    is_1x1_config  = 1'b0;
    errors         = 0;
    cur_test       = 0;
    total          = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      test_err[i]   = 0;
      test_beats[i] = 0;
    end
    test_name = '{"reset", "scale and bias", "leaky slope", "saturation",
                  "coefficient cycling", "back-to-back timing"};
    build_table();
    model_table();
    table_ready = 1'b1;

    @(posedge clk);
    s_valid <= 1'b0;
    repeat (RESET_CYCLES - 2) @(posedge clk);
    @(negedge clk);
    check_value("m_valid", 64'(m_valid), 64'd0, 0);
    @(posedge clk);
    rst_n <= 1'b1;
    $display("test 0 %s: %0d errors", test_name[0], test_err[0]);

    for (int t = 1; t < NUM_TESTS; t++) begin
      cur_test = t;
      foreach (rows[i]) begin
        if (rows[i].test == t) begin
          apply_row(rows[i]);
        end
      end
      drive_idle();
      while (exp_q.size() != 0) begin
        @(negedge clk);
      end
      @(negedge clk);
      $display("test %0d %s: %0d beats, %0d errors", t, test_name[t], test_beats[t],
               test_err[t]);
      total += test_beats[t];
    end

    $display("%0d tests, %0d beats checked, %0d errors", NUM_TESTS, total, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
lrelu_cfg_pkg.sv
lrelu_data_pkg.sv
lrelu_config_loader.sv
lrelu_coeff_store.sv
lrelu_datapath.sv
lrelu_engine.sv
lrelu_engine_assert.sv
tb_lrelu_engine.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module tb_lrelu_engine -f verilog.f

out=$(./obj_dir/Vtb_lrelu_engine)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
  exit 0
else
  exit 1
fi
